/* kdi_width_pkg.sv */
// Widths and vector types shared by the key derivation unit
// Everything here is counted in 64-bit digest blocks
// Modules refer to these names with the package scope

package kdi_width_pkg;

  // One digest block, also the width of one entropy word
  parameter int unsigned BlockWidth = 64;

  // Blocks per derived key
  parameter int unsigned KeyBlocks = 2;

  // Blocks per key seed, two per key half
  parameter int unsigned SeedBlocks = 4;

  // Entropy words that make up the nonce
  parameter int unsigned NonceChunks = 2;

  typedef logic [BlockWidth-1:0]             block_t;
  typedef logic [KeyBlocks*BlockWidth-1:0]   key_t;
  typedef logic [SeedBlocks*BlockWidth-1:0]  seed_t;
  typedef logic [NonceChunks*BlockWidth-1:0] nonce_t;

  // Seed and entropy counter value
  typedef logic [1:0] cnt_t;

endpackage

/* kdi_ctrl_pkg.sv */
// Control encodings of the key derivation unit
// Digest commands, constant selects, requester indices and FSM states,
// plus the configuration bundle that travels with a granted request

package kdi_ctrl_pkg;

  // Commands to the digest datapath
  typedef enum logic [1:0] {
    CmdInit,
    CmdLoad,
    CmdDigest,
    CmdFinalize
  } digest_cmd_e;

  // Netlist constant used by the digest
  typedef enum logic [1:0] {
    FlashDataKey,
    FlashAddrKey,
    SramDataKey
  } digest_sel_e;

  // Requester index, also the round-robin order
  typedef enum logic [1:0] {
    ReqFlashData,
    ReqFlashAddr,
    ReqSram
  } req_idx_e;

  typedef enum logic [3:0] {
    ResetSt,
    IdleSt,
    DigClrSt,
    DigLoadSt,
    FetchEntropySt,
    DigEntropySt,
    DigFinSt,
    DigWaitSt,
    FetchNonceSt,
    FinishSt,
    ErrorSt
  } kdi_state_e;

  // Settings of the request in service
  typedef struct packed {
    logic                  ingest_entropy;
    digest_sel_e           digest_sel;
    logic                  nonce_last;
    logic                  seed_valid;
    kdi_width_pkg::seed_t  seed;
  } req_cfg_t;

endpackage

/* kdi_ifs.sv */
// Internal interfaces of the key derivation unit
// kdi_req_if carries the granted request from the arbiter to the FSM
// and the key store, kdi_store_if carries the FSM's register writes
// and data select to the key store

interface kdi_req_if;

  logic                   valid;
  kdi_ctrl_pkg::req_cfg_t cfg;
  // Pulse at the end of a derivation
  logic                   done;

  modport arb   (output valid, output cfg, input done);
  modport fsm   (input valid, input cfg, output done);
  modport store (input cfg);

endinterface

interface kdi_store_if;

  // Digest result into key half key_idx
  logic                 key_we;
  logic                 key_idx;
  // Entropy word into nonce chunk nonce_idx
  logic                 nonce_we;
  logic                 nonce_idx;
  logic                 seed_valid_we;
  // High while entropy blocks go to the digest
  logic                 data_sel;
  kdi_width_pkg::cnt_t  seed_idx;
  logic                 ent_idx;

  modport fsm (
    output key_we, key_idx, nonce_we, nonce_idx, seed_valid_we,
    output data_sel, seed_idx, ent_idx
  );
  modport store (
    input key_we, key_idx, nonce_we, nonce_idx, seed_valid_we,
    input data_sel, seed_idx, ent_idx
  );

endinterface

/* kdi_req_arb.sv */
// Request side of the key derivation unit
// Round-robin arbiter over the flash data, flash address and SRAM key
// requests. The grant is locked while a request is in service and the
// FSM's done pulse becomes the ack of the granted requester.

module kdi_req_arb (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flash_data_req_i,
  input  logic                 flash_addr_req_i,
  input  logic                 sram_req_i,
  input  logic                 seed_valid_i,
  input  kdi_width_pkg::seed_t flash_data_seed_i,
  input  kdi_width_pkg::seed_t flash_addr_seed_i,
  input  kdi_width_pkg::key_t  sram_seed_i,
  output logic                 flash_data_ack_o,
  output logic                 flash_addr_ack_o,
  output logic                 sram_ack_o,
  kdi_req_if.arb               req
);

  localparam int unsigned NumReq = 3;

  logic [NumReq-1:0]      req_vec;
  logic                   busy_q;
  kdi_ctrl_pkg::req_idx_e prio_q, pick_idx, gnt_idx, gnt_q, next_prio;

  // Bit order follows req_idx_e
  assign req_vec = {sram_req_i, flash_addr_req_i, flash_data_req_i};

  // Pick the first request at or after the priority pointer
  always_comb begin : p_pick
    int unsigned cand;
    pick_idx = prio_q;
    // Walk backwards so the nearest request is assigned last
    for (int unsigned k = NumReq; k > 0; k--) begin
      cand = (int'(prio_q) + k - 1) % NumReq;
      if (req_vec[cand]) begin
        pick_idx = kdi_ctrl_pkg::req_idx_e'(cand);
      end
    end
  end

  // Zero-cycle grant, held while busy
  assign gnt_idx   = busy_q ? gnt_q : pick_idx;
  assign req.valid = busy_q | (|req_vec);
  assign next_prio = kdi_ctrl_pkg::req_idx_e'((int'(gnt_idx) + 1) % NumReq);

  // Fixed settings per requester
  always_comb begin : p_cfg
    case (gnt_idx)
      kdi_ctrl_pkg::ReqFlashData: begin
        req.cfg = '{ingest_entropy: 1'b0,
                    digest_sel:     kdi_ctrl_pkg::FlashDataKey,
                    nonce_last:     1'b1,
                    seed_valid:     seed_valid_i,
                    seed:           flash_data_seed_i};
      end
      kdi_ctrl_pkg::ReqFlashAddr: begin
        // Single nonce word
        req.cfg = '{ingest_entropy: 1'b0,
                    digest_sel:     kdi_ctrl_pkg::FlashAddrKey,
                    nonce_last:     1'b0,
                    seed_valid:     seed_valid_i,
                    seed:           flash_addr_seed_i};
      end
      default: begin
        // SRAM seed fills both key halves
        req.cfg = '{ingest_entropy: 1'b1,
                    digest_sel:     kdi_ctrl_pkg::SramDataKey,
                    nonce_last:     1'b1,
                    seed_valid:     seed_valid_i,
                    seed:           {sram_seed_i, sram_seed_i}};
      end
    endcase
  end

  // Done turns into the ack of whoever holds the grant
  assign flash_data_ack_o = req.done && (gnt_idx == kdi_ctrl_pkg::ReqFlashData);
  assign flash_addr_ack_o = req.done && (gnt_idx == kdi_ctrl_pkg::ReqFlashAddr);
  assign sram_ack_o       = req.done && (gnt_idx == kdi_ctrl_pkg::ReqSram);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      busy_q <= 1'b0;
      gnt_q  <= kdi_ctrl_pkg::ReqFlashData;
      prio_q <= kdi_ctrl_pkg::ReqFlashData;
    end else begin
      gnt_q <= gnt_idx;
      if (req.done) begin
        // Release and move priority past the served requester
        busy_q <= 1'b0;
        prio_q <= next_prio;
      end else if (req.valid) begin
        busy_q <= 1'b1;
      end
    end
  end

endmodule

/* kdi_ctrl_fsm.sv */
// Derivation FSM of the key derivation unit
// Per key half: digest init, two seed blocks, optional entropy blocks,
// finalize and wait for the 64-bit result. Afterwards the nonce words
// are fetched and the request is completed with a done pulse.
// EntropyBlocks sets how many entropy words are ingested.

module kdi_ctrl_fsm #(
  parameter int unsigned EntropyBlocks = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       kdi_en_i,
  input  logic                       escalate_i,
  output logic                       fsm_err_o,
  output logic                       edn_req_o,
  input  logic                       edn_ack_i,
  output logic                       scrmbl_valid_o,
  input  logic                       scrmbl_ready_i,
  output kdi_ctrl_pkg::digest_cmd_e  scrmbl_cmd_o,
  output kdi_ctrl_pkg::digest_sel_e  scrmbl_sel_o,
  input  logic                       scrmbl_valid_i,
  kdi_req_if.fsm                     req,
  kdi_store_if.fsm                   store
);

  localparam kdi_width_pkg::cnt_t EntLast = kdi_width_pkg::cnt_t'(EntropyBlocks - 1);

  kdi_ctrl_pkg::kdi_state_e state_d, state_q;
  kdi_width_pkg::cnt_t      seed_cnt_d, seed_cnt_q;
  kdi_width_pkg::cnt_t      ent_cnt_d, ent_cnt_q;
  logic                     edn_req_d, edn_req_q;

  assign edn_req_o    = edn_req_q;
  assign scrmbl_sel_o = req.cfg.digest_sel;

  // Indices follow the counters directly
  assign store.key_idx   = seed_cnt_q[1];
  assign store.seed_idx  = seed_cnt_q;
  assign store.nonce_idx = ent_cnt_q[0];
  assign store.ent_idx   = ent_cnt_q[0];

  always_comb begin : p_fsm
    state_d             = state_q;
    seed_cnt_d          = seed_cnt_q;
    ent_cnt_d           = ent_cnt_q;
    fsm_err_o           = 1'b0;
    // An open entropy request only ends with its ack
    edn_req_d           = edn_req_q & ~edn_ack_i;
    scrmbl_valid_o      = 1'b0;
    scrmbl_cmd_o        = kdi_ctrl_pkg::CmdLoad;
    store.key_we        = 1'b0;
    store.nonce_we      = 1'b0;
    store.seed_valid_we = 1'b0;
    store.data_sel      = 1'b0;
    req.done            = 1'b0;

    case (state_q)
      ////////////////////////////////////////////////////////////////////////////
      // Idle until enabled, then wait for a request
      kdi_ctrl_pkg::ResetSt: begin
        if (kdi_en_i) begin
          state_d = kdi_ctrl_pkg::IdleSt;
        end
      end
      kdi_ctrl_pkg::IdleSt: begin
        if (req.valid) begin
          state_d    = kdi_ctrl_pkg::DigClrSt;
          seed_cnt_d = '0;
          ent_cnt_d  = '0;
        end
      end
      ////////////////////////////////////////////////////////////////////////////
      // Digest sequence for one key half
      kdi_ctrl_pkg::DigClrSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_ctrl_pkg::CmdInit;
        if (scrmbl_ready_i) begin
          state_d = kdi_ctrl_pkg::DigLoadSt;
        end
      end
      kdi_ctrl_pkg::DigLoadSt: begin
        scrmbl_valid_o = 1'b1;
        // Odd block triggers the digest round
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_ctrl_pkg::CmdDigest;
          if (scrmbl_ready_i) begin
            state_d = req.cfg.ingest_entropy ? kdi_ctrl_pkg::FetchEntropySt :
                                               kdi_ctrl_pkg::DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_d = seed_cnt_q + 1'b1;
        end
      end
      kdi_ctrl_pkg::FetchEntropySt: begin
        // Keep requesting until the last word arrives
        edn_req_d = ~edn_ack_i | (ent_cnt_q != EntLast);
        if (edn_ack_i) begin
          store.nonce_we = 1'b1;
          if (ent_cnt_q == EntLast) begin
            state_d   = kdi_ctrl_pkg::DigEntropySt;
            ent_cnt_d = '0;
          end else begin
            ent_cnt_d = ent_cnt_q + 1'b1;
          end
        end
      end
      kdi_ctrl_pkg::DigEntropySt: begin
        scrmbl_valid_o = 1'b1;
        store.data_sel = 1'b1;
        if (ent_cnt_q == EntLast) begin
          scrmbl_cmd_o = kdi_ctrl_pkg::CmdDigest;
          if (scrmbl_ready_i) begin
            state_d   = kdi_ctrl_pkg::DigFinSt;
            ent_cnt_d = '0;
          end
        end else if (scrmbl_ready_i) begin
          ent_cnt_d = ent_cnt_q + 1'b1;
        end
      end
      kdi_ctrl_pkg::DigFinSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_ctrl_pkg::CmdFinalize;
        if (scrmbl_ready_i) begin
          state_d = kdi_ctrl_pkg::DigWaitSt;
        end
      end
      kdi_ctrl_pkg::DigWaitSt: begin
        if (scrmbl_valid_i) begin
          store.key_we = 1'b1;
          // First half done, restart the digest on seed blocks 2 and 3
          if (seed_cnt_q == 2'd1) begin
            seed_cnt_d = seed_cnt_q + 1'b1;
            state_d    = kdi_ctrl_pkg::DigClrSt;
          end else begin
            seed_cnt_d          = '0;
            store.seed_valid_we = 1'b1;
            state_d             = kdi_ctrl_pkg::FetchNonceSt;
          end
        end
      end
      ////////////////////////////////////////////////////////////////////////////
      // Nonce and completion
      kdi_ctrl_pkg::FetchNonceSt: begin
        edn_req_d = ~edn_ack_i | (ent_cnt_q != {1'b0, req.cfg.nonce_last});
        if (edn_ack_i) begin
          store.nonce_we = 1'b1;
          if (ent_cnt_q == {1'b0, req.cfg.nonce_last}) begin
            state_d   = kdi_ctrl_pkg::FinishSt;
            ent_cnt_d = '0;
          end else begin
            ent_cnt_d = ent_cnt_q + 1'b1;
          end
        end
      end
      kdi_ctrl_pkg::FinishSt: begin
        req.done = 1'b1;
        state_d  = kdi_ctrl_pkg::IdleSt;
      end
      kdi_ctrl_pkg::ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      // Illegal state code
      default: begin
        state_d   = kdi_ctrl_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation wins, but a pending entropy request stays up
    if (escalate_i) begin
      state_d   = kdi_ctrl_pkg::ErrorSt;
      fsm_err_o = 1'b1;
      edn_req_d = edn_req_q & ~edn_ack_i;
      req.done  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= kdi_ctrl_pkg::ResetSt;
      seed_cnt_q <= '0;
      ent_cnt_q  <= '0;
      edn_req_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      seed_cnt_q <= seed_cnt_d;
      ent_cnt_q  <= ent_cnt_d;
      edn_req_q  <= edn_req_d;
    end
  end

  // Req/ack rule of the entropy port
  edn_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o);

endmodule

/* kdi_key_store.sv */
// Output registers of the key derivation unit
// Holds the key halves, the nonce chunks and the seed-valid flag that
// all requesters share, and selects the block sent to the digest

module kdi_key_store (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  kdi_width_pkg::block_t scrmbl_data_i,
  input  kdi_width_pkg::block_t edn_data_i,
  output kdi_width_pkg::block_t scrmbl_data_o,
  output kdi_width_pkg::key_t   key_o,
  output kdi_width_pkg::nonce_t nonce_o,
  output logic                  seed_valid_o,
  kdi_store_if.store            store,
  kdi_req_if.store              req
);

  kdi_width_pkg::block_t [kdi_width_pkg::KeyBlocks-1:0]   key_q;
  kdi_width_pkg::block_t [kdi_width_pkg::NonceChunks-1:0] nonce_q;
  kdi_width_pkg::block_t [kdi_width_pkg::SeedBlocks-1:0]  seed_blocks;
  logic                                                   seed_valid_q;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

  // Seed split into digest blocks, block 0 in the low bits
  assign seed_blocks = req.cfg.seed;

  // Entropy comes back out of the nonce register.
  // An invalid seed reaches the digest as zeros
  always_comb begin : p_data_sel
    if (store.data_sel) begin
      scrmbl_data_o = nonce_q[store.ent_idx];
    end else if (req.cfg.seed_valid) begin
      scrmbl_data_o = seed_blocks[store.seed_idx];
    end else begin
      scrmbl_data_o = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      if (store.key_we) begin
        key_q[store.key_idx] <= scrmbl_data_i;
      end
      if (store.nonce_we) begin
        nonce_q[store.nonce_idx] <= edn_data_i;
      end
      if (store.seed_valid_we) begin
        seed_valid_q <= req.cfg.seed_valid;
      end
    end
  end

  // Digest result and entropy word never arrive in the same cycle
  key_nonce_we_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(store.key_we && store.nonce_we));

endmodule

/* otp_kdi.sv */
// Key derivation unit for the OTP controller scrambling keys
// Serves flash data, flash address and SRAM key requests one at a time
// through an external digest datapath and an entropy req/ack port.
// Key, nonce and seed-valid outputs are shared by all requesters.

module otp_kdi #(
  parameter int unsigned EntropyBlocks = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      kdi_en_i,
  input  logic                      escalate_i,
  output logic                      fsm_err_o,
  // Seeds from OTP
  input  logic                      seed_valid_i,
  input  kdi_width_pkg::seed_t      flash_data_seed_i,
  input  kdi_width_pkg::seed_t      flash_addr_seed_i,
  input  kdi_width_pkg::key_t       sram_seed_i,
  // Key requests
  input  logic                      flash_data_req_i,
  output logic                      flash_data_ack_o,
  input  logic                      flash_addr_req_i,
  output logic                      flash_addr_ack_o,
  input  logic                      sram_req_i,
  output logic                      sram_ack_o,
  output kdi_width_pkg::key_t       key_o,
  output kdi_width_pkg::nonce_t     nonce_o,
  output logic                      seed_valid_o,
  // Entropy port
  output logic                      edn_req_o,
  input  logic                      edn_ack_i,
  input  kdi_width_pkg::block_t     edn_data_i,
  // Digest datapath
  output logic                      scrmbl_valid_o,
  input  logic                      scrmbl_ready_i,
  output kdi_ctrl_pkg::digest_cmd_e scrmbl_cmd_o,
  output kdi_ctrl_pkg::digest_sel_e scrmbl_sel_o,
  output kdi_width_pkg::block_t     scrmbl_data_o,
  input  logic                      scrmbl_valid_i,
  input  kdi_width_pkg::block_t     scrmbl_data_i
);

  kdi_req_if   req_if ();
  kdi_store_if store_if ();

  kdi_req_arb u_req_arb (
    .clk_i,
    .rst_ni,
    .flash_data_req_i,
    .flash_addr_req_i,
    .sram_req_i,
    .seed_valid_i,
    .flash_data_seed_i,
    .flash_addr_seed_i,
    .sram_seed_i,
    .flash_data_ack_o,
    .flash_addr_ack_o,
    .sram_ack_o,
    .req              (req_if.arb)
  );

  kdi_ctrl_fsm #(
    .EntropyBlocks(EntropyBlocks)
  ) u_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .escalate_i,
    .fsm_err_o,
    .edn_req_o,
    .edn_ack_i,
    .scrmbl_valid_o,
    .scrmbl_ready_i,
    .scrmbl_cmd_o,
    .scrmbl_sel_o,
    .scrmbl_valid_i,
    .req            (req_if.fsm),
    .store          (store_if.fsm)
  );

  kdi_key_store u_key_store (
    .clk_i,
    .rst_ni,
    .scrmbl_data_i,
    .edn_data_i,
    .scrmbl_data_o,
    .key_o,
    .nonce_o,
    .seed_valid_o,
    .store         (store_if.store),
    .req           (req_if.store)
  );

endmodule

/* tb_clk_gen.sv */
// Clock and reset source for the key derivation unit testbench
// Free running clock and an active low reset held for ResetCycles
// clock cycles, released on a falling edge

module tb_clk_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_otp_kdi.sv */
// Testbench of the key derivation unit
// Reads request cases from kdi_stimulus.txt, models the digest datapath
// and the entropy source, and checks key, nonce, digested blocks and acks.
// Inputs change on the falling clock edge, outputs are sampled there too.

module tb_otp_kdi;

  localparam int unsigned CaseWords = 16;
  localparam int unsigned NumCases  = 7;
  localparam int unsigned MaxCycles = 2000;

  logic clk, rst_n;
  logic kdi_en_i, escalate_i, fsm_err_o, seed_valid_i, seed_valid_o;
  kdi_width_pkg::seed_t  flash_data_seed_i, flash_addr_seed_i;
  kdi_width_pkg::key_t   sram_seed_i, key_o;
  kdi_width_pkg::nonce_t nonce_o;
  logic flash_data_req_i, flash_addr_req_i, sram_req_i;
  logic flash_data_ack_o, flash_addr_ack_o, sram_ack_o;
  logic edn_req_o, edn_ack_i, scrmbl_valid_o, scrmbl_ready_i, scrmbl_valid_i;
  kdi_width_pkg::block_t     edn_data_i, scrmbl_data_o, scrmbl_data_i;
  kdi_ctrl_pkg::digest_cmd_e scrmbl_cmd_o;
  kdi_ctrl_pkg::digest_sel_e scrmbl_sel_o;

  // Sixteen words per case in the order mode req seed_valid stall seed0..3 ret0 ret1 ent0..5
  kdi_width_pkg::block_t stim_mem [0:NumCases*CaseWords-1];

  // Model state
  kdi_width_pkg::block_t ret_q[$], ent_q[$], data_q[$];
  logic [1:0] exp_sel;
  int         fin_wait, ent_delay;
  int         init_cnt;
  // Expected nonce register contents
  kdi_width_pkg::nonce_t nonce_model;

  tb_clk_gen #(.Period(8), .ResetCycles(4)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  otp_kdi otp_kdi_i (
    .clk_i(clk), .rst_ni(rst_n), .kdi_en_i, .escalate_i, .fsm_err_o,
    .seed_valid_i, .flash_data_seed_i, .flash_addr_seed_i, .sram_seed_i,
    .flash_data_req_i, .flash_data_ack_o, .flash_addr_req_i, .flash_addr_ack_o,
    .sram_req_i, .sram_ack_o, .key_o, .nonce_o, .seed_valid_o,
    .edn_req_o, .edn_ack_i, .edn_data_i,
    .scrmbl_valid_o, .scrmbl_ready_i, .scrmbl_cmd_o, .scrmbl_sel_o,
    .scrmbl_data_o, .scrmbl_valid_i, .scrmbl_data_i
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [255:0] exp_v,
                             input logic [255:0] act_v);
    if (exp_v !== act_v) begin
      $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
      stop_with_error("value mismatch");
    end
  endtask

  function automatic kdi_width_pkg::block_t field(input int c, input int k);
    return stim_mem[c*CaseWords+k];
  endfunction

  // Single bit flag of a stimulus word
  function automatic logic flag(input int c, input int k);
    return stim_mem[c*CaseWords+k][0];
  endfunction

  // Ack vector with flash data in bit 0 and sram in bit 2
  function automatic logic [2:0] acks();
    return {sram_ack_o, flash_addr_ack_o, flash_data_ack_o};
  endfunction

  task automatic set_req(input int idx, input logic val);
    case (idx)
      0: flash_data_req_i = val;
      1: flash_addr_req_i = val;
      default: sram_req_i = val;
    endcase
  endtask

  task automatic apply_seed(input int c);
    case (int'(field(c, 1)))
      0: flash_data_seed_i = {field(c, 7), field(c, 6), field(c, 5), field(c, 4)};
      1: flash_addr_seed_i = {field(c, 7), field(c, 6), field(c, 5), field(c, 4)};
      default: sram_seed_i = {field(c, 5), field(c, 4)};
    endcase
  endtask

  // One falling edge worth of digest and entropy model activity
  task automatic step_models(input logic stall);
    scrmbl_valid_i = 1'b0;
    if (fin_wait > 0) begin
      fin_wait--;
      if (fin_wait == 0) begin
        if (ret_q.size() == 0) begin
          stop_with_error("digest model has no return value left");
        end else begin
          scrmbl_valid_i = 1'b1;
          scrmbl_data_i  = ret_q.pop_front();
        end
      end
    end
    scrmbl_ready_i = stall ? 1'($urandom % 2) : 1'b1;
    if (scrmbl_valid_o && scrmbl_ready_i) begin
      check_value("digest select", exp_sel, scrmbl_sel_o);
      if (scrmbl_cmd_o == kdi_ctrl_pkg::CmdInit) begin
        init_cnt++;
      end else if (scrmbl_cmd_o == kdi_ctrl_pkg::CmdLoad ||
                   scrmbl_cmd_o == kdi_ctrl_pkg::CmdDigest) begin
        data_q.push_back(scrmbl_data_o);
      end else if (scrmbl_cmd_o == kdi_ctrl_pkg::CmdFinalize) begin
        fin_wait = 1 + ($urandom % 4);
      end
    end
    // Entropy source gives one word per ack
    if (edn_ack_i) begin
      edn_ack_i = 1'b0;
      ent_delay = -1;
    end else if (edn_req_o) begin
      if (ent_delay < 0) begin
        ent_delay = $urandom % 4;
      end
      if (ent_delay > 0) begin
        ent_delay--;
      end else if (ent_q.size() == 0) begin
        stop_with_error("entropy model has no word left");
      end else begin
        edn_ack_i  = 1'b1;
        edn_data_i = ent_q.pop_front();
        ent_delay  = -1;
      end
    end
  endtask

  // Serve one already raised request and check its results
  task automatic run_service(input int c, input logic sv);
    int idx;
    int cycles;
    logic stall;
    kdi_width_pkg::nonce_t exp_nonce;
    kdi_width_pkg::block_t exp_q[$];
    kdi_width_pkg::block_t e [6];
    idx        = int'(field(c, 1));
    stall      = flag(c, 3);
    ret_q      = {field(c, 8), field(c, 9)};
    for (int k = 0; k < 6; k++) begin
      e[k] = field(c, 10 + k);
    end
    ent_q    = {e[0], e[1], e[2], e[3], e[4], e[5]};
    data_q   = {};
    fin_wait = 0;
    init_cnt = 0;
    case (idx)
      0: exp_sel = kdi_ctrl_pkg::FlashDataKey;
      1: exp_sel = kdi_ctrl_pkg::FlashAddrKey;
      default: exp_sel = kdi_ctrl_pkg::SramDataKey;
    endcase
    cycles = 0;
    do begin
      @(negedge clk);
      step_models(stall);
      cycles++;
      if (cycles > MaxCycles) begin
        stop_with_error("timeout waiting for the request ack");
      end else if (acks() != 3'b000 && acks() != 3'(1 << idx)) begin
        stop_with_error("ack went to the wrong requester");
      end
    end while (acks() == 3'b000);
    set_req(idx, 1'b0);

    // Two seed blocks per key half and for SRAM two entropy blocks after them
    for (int h = 0; h < 2; h++) begin
      for (int b = 2 * h; b < 2 * h + 2; b++) begin
        exp_q.push_back(!sv ? '0 : (idx == 2) ? field(c, 4 + b % 2) : field(c, 4 + b));
      end
      if (idx == 2) begin
        exp_q.push_back(e[2*h]);
        exp_q.push_back(e[2*h+1]);
      end
    end
    check_value("digest init count", 2, init_cnt);
    check_value("digested block count", exp_q.size(), data_q.size());
    foreach (exp_q[k]) begin
      check_value($sformatf("digested block %0d", k), exp_q[k], data_q[k]);
    end
    case (idx)
      0: exp_nonce = {e[1], e[0]};
      1: exp_nonce = {nonce_model[127:64], e[0]};
      default: exp_nonce = {e[5], e[4]};
    endcase
    check_value("key", {field(c, 9), field(c, 8)}, key_o);
    check_value("nonce", exp_nonce, nonce_o);
    check_value("seed valid", sv, seed_valid_o);
    nonce_model = exp_nonce;
  endtask

  // Escalate while an entropy request is open
  task automatic run_escalation(input int c);
    int cycles;
    ent_q    = {field(c, 10)};
    ret_q    = {field(c, 8), field(c, 9)};
    data_q   = {};
    fin_wait = 0;
    exp_sel  = kdi_ctrl_pkg::SramDataKey;
    seed_valid_i = flag(c, 2);
    apply_seed(c);
    sram_req_i = 1'b1;
    cycles = 0;
    forever begin
      @(negedge clk);
      cycles++;
      if (edn_req_o) break;
      if (cycles > MaxCycles) begin
        stop_with_error("timeout waiting for the entropy request");
      end else begin
        step_models(1'b0);
      end
    end
    escalate_i = 1'b1;
    @(negedge clk);
    escalate_i = 1'b0;
    repeat (3) begin
      check_value("error flag", 1'b1, fsm_err_o);
      check_value("open entropy request", 1'b1, edn_req_o);
      @(negedge clk);
    end
    edn_ack_i  = 1'b1;
    edn_data_i = ent_q.pop_front();
    @(negedge clk);
    edn_ack_i = 1'b0;
    check_value("entropy request after ack", 1'b0, edn_req_o);
    repeat (20) begin
      check_value("acks after escalation", 3'b000, acks());
      check_value("error flag", 1'b1, fsm_err_o);
      check_value("digest valid in error", 1'b0, scrmbl_valid_o);
      @(negedge clk);
    end
    sram_req_i = 1'b0;
  endtask

  initial begin : p_main
    int c;
    int cycles;
    void'($urandom(32'h9f1a4a72));
    kdi_en_i = 1'b0;
    escalate_i = 1'b0;
    seed_valid_i = 1'b0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i = '0;
    flash_data_req_i = 1'b0;
    flash_addr_req_i = 1'b0;
    sram_req_i = 1'b0;
    edn_ack_i = 1'b0;
    edn_data_i = '0;
    scrmbl_ready_i = 1'b0;
    scrmbl_valid_i = 1'b0;
    scrmbl_data_i = '0;
    fin_wait = 0;
    ent_delay = -1;
    init_cnt = 0;
    nonce_model = '0;
    $readmemh("kdi_stimulus.txt", stim_mem);

    cycles = 0;
    while (!rst_n) begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) stop_with_error("reset never released");
    end
    check_value("acks after reset", 3'b000, acks());
    check_value("entropy request after reset", 1'b0, edn_req_o);
    check_value("digest valid after reset", 1'b0, scrmbl_valid_o);
    check_value("error flag after reset", 1'b0, fsm_err_o);

    // A held request stays unanswered until the enable pulse
    seed_valid_i = flag(0, 2);
    apply_seed(0);
    set_req(int'(field(0, 1)), 1'b1);
    repeat (10) begin
      @(negedge clk);
      check_value("ack before enable", 3'b000, acks());
      check_value("digest valid before enable", 1'b0, scrmbl_valid_o);
    end
    kdi_en_i = 1'b1;
    @(negedge clk);
    kdi_en_i = 1'b0;

    c = 0;
    while (c < NumCases) begin
      case (int'(field(c, 0)))
        0: begin
          seed_valid_i = flag(c, 2);
          apply_seed(c);
          set_req(int'(field(c, 1)), 1'b1);
          run_service(c, flag(c, 2));
          c++;
        end
        1: begin
          // Three requests at once are served in round-robin order
          seed_valid_i = flag(c, 2);
          for (int k = 0; k < 3; k++) begin
            apply_seed(c + k);
            set_req(int'(field(c + k, 1)), 1'b1);
          end
          for (int k = 0; k < 3; k++) begin
            run_service(c + k, flag(c, 2));
          end
          c += 3;
        end
        default: begin
          run_escalation(c);
          c++;
        end
      endcase
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* kdi_stimulus.txt */
// Line A: mode(0 single,1 group of 3,2 escalate) req(0 fdata,1 faddr,2 sram) sv stall seed0..3
// Line B: digest return 0, digest return 1, entropy words 0..5
0 0 1 0 5eed00000000a000 5eed00000000a001 5eed00000000a002 5eed00000000a003
d1000000000000a0 d1000000000000a1 e00000a0 e00000a1 e00000a2 e00000a3 e00000a4 e00000a5
0 1 0 1 5eed00000000b000 5eed00000000b001 5eed00000000b002 5eed00000000b003
d1000000000000b0 d1000000000000b1 e00000b0 e00000b1 e00000b2 e00000b3 e00000b4 e00000b5
0 2 1 0 5eed00000000c000 5eed00000000c001 0 0
d1000000000000c0 d1000000000000c1 e00000c0 e00000c1 e00000c2 e00000c3 e00000c4 e00000c5
1 0 1 1 5eed00000000d000 5eed00000000d001 5eed00000000d002 5eed00000000d003
d1000000000000d0 d1000000000000d1 e00000d0 e00000d1 e00000d2 e00000d3 e00000d4 e00000d5
1 1 1 1 5eed00000000e000 5eed00000000e001 5eed00000000e002 5eed00000000e003
d1000000000000e0 d1000000000000e1 e00000e0 e00000e1 e00000e2 e00000e3 e00000e4 e00000e5
1 2 1 1 5eed00000000f000 5eed00000000f001 0 0
d1000000000000f0 d1000000000000f1 e00000f0 e00000f1 e00000f2 e00000f3 e00000f4 e00000f5
2 2 1 0 5eed000000001000 5eed000000001001 0 0
d100000000000010 d100000000000011 e0000010 e0000011 e0000012 e0000013 e0000014 e0000015

/* verilog.f */
kdi_width_pkg.sv
kdi_ctrl_pkg.sv
kdi_ifs.sv
kdi_req_arb.sv
kdi_ctrl_fsm.sv
kdi_key_store.sv
otp_kdi.sv
tb_clk_gen.sv
tb_otp_kdi.sv

/* Bender.yml */
package:
  name: otp_kdi

sources:
  - kdi_width_pkg.sv
  - kdi_ctrl_pkg.sv
  - kdi_ifs.sv
  - kdi_req_arb.sv
  - kdi_ctrl_fsm.sv
  - kdi_key_store.sv
  - otp_kdi.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_otp_kdi.sv
